//--- filelist.f
+incdir+include
logic/decoder_pkg.sv
logic/capture_if.sv
logic/instr_capture.sv
logic/instr_decode.sv
logic/operand_select.sv
logic/decoder_top.sv
test/decoder_tb.sv

//--- Bender.yml
package:
  name: instr_decoder

sources:
  - files:
      - logic/decoder_pkg.sv
      - logic/capture_if.sv
      - logic/instr_capture.sv
      - logic/instr_decode.sv
      - logic/operand_select.sv
      - logic/decoder_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/decoder_tb.sv

//--- include/decoder_ref.svh
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

// Expected decoder outputs for one cycle
typedef struct packed {
    decoder_pkg::actions_t actions;
    decoder_pkg::word_t    alu_src1;
    decoder_pkg::word_t    alu_src2;
    decoder_pkg::cycle_t   cycle_next;
} ref_out_t;

function automatic ref_out_t decode_ref(
    input decoder_pkg::word_t  first_word,
    input decoder_pkg::word_t  imm_word,
    input decoder_pkg::pc_t    pc_cur,
    input decoder_pkg::pc_t    pc_prev,
    input logic                flushed,
    input decoder_pkg::cycle_t cycle,
    input decoder_pkg::word_t  reg1,
    input decoder_pkg::word_t  reg2
);
    ref_out_t   r;
    logic [3:0] op;
    logic [3:0] f1;
    logic [3:0] f2;
    logic [3:0] f3;
    r  = '0;
    op = first_word[3:0];
    f1 = first_word[7:4];
    f2 = first_word[11:8];
    f3 = first_word[15:12];
    if (!flushed) begin
        if (op == 4'd6 || op == 4'd7) begin
            r.actions  = {3'b000, 1'b1, 1'b0, op == 4'd7, 4'b0010};
            r.alu_src1 = reg1;
            r.alu_src2 = reg2;
        end else if (op == 4'd1 && f2 == 4'd3) begin
            r.cycle_next = (cycle == 0) ? 3'd1 : 3'd0;
            r.actions    = (cycle == 0) ? '0 : 10'b0000_0000_11;
            r.alu_src2   = (cycle == 0) ? '0 : imm_word;
        end else if (op == 4'd1 && f2 == 4'd4) begin
            r.actions  = 10'b0000_0000_11;
            r.alu_src2 = decoder_pkg::word_t'(f3);
        end else if (op == 4'd3 && f1 <= 4'd3) begin
            r.actions.branch_eq = (f1 == 4'd0) || (f1 == 4'd2);
            r.actions.branch_gt = (f1 == 4'd1) || (f1 == 4'd2);
            r.actions.branch_lt = (f1 == 4'd1) || (f1 == 4'd3);
            r.actions.alu_add   = 1'b1;
            if (cycle == 0) begin
                r.cycle_next           = 3'd1;
                r.actions.alu_neg_src1 = (f1 <= 4'd1);
                r.actions.alu_neg_src2 = (f1 >= 4'd2);
                r.alu_src1             = reg1;
                r.alu_src2             = reg2;
            end else begin
                r.alu_src1 = imm_word;
                r.alu_src2 = decoder_pkg::word_t'(pc_prev);
            end
        end else if (op == 4'd2 && f3 == 4'd0 && cycle == 0) begin
            r.cycle_next = 3'd1;
        end else if (op == 4'd2 && f3 <= 4'd1) begin
            r.actions  = 10'b0001_0011_10;
            r.alu_src1 = (f3 == 4'd0) ? imm_word : reg1;
            r.alu_src2 = decoder_pkg::word_t'((f3 == 4'd0) ? pc_prev : pc_cur);
        end
    end
    return r;
endfunction

// Instruction words, fields from bit 15 down to bit 0
function automatic decoder_pkg::word_t make_r(input decoder_pkg::opcode_e op,
        input decoder_pkg::reg_idx_t res, input decoder_pkg::reg_idx_t s1,
        input decoder_pkg::reg_idx_t s2);
    return {s2, s1, res, op};
endfunction

function automatic decoder_pkg::word_t make_u(input decoder_pkg::imm_func_e f,
        input decoder_pkg::reg_idx_t res, input logic [3:0] imma);
    return {imma, f, res, decoder_pkg::U_TYPE};
endfunction

function automatic decoder_pkg::word_t make_s(input decoder_pkg::branch_func_e f,
        input decoder_pkg::reg_idx_t s1, input decoder_pkg::reg_idx_t s2);
    return {s2, s1, f, decoder_pkg::S_TYPE};
endfunction

function automatic decoder_pkg::word_t make_j(input decoder_pkg::jump_func_e f,
        input decoder_pkg::reg_idx_t res, input decoder_pkg::reg_idx_t s1);
    return {f, s1, res, decoder_pkg::J_TYPE};
endfunction

`endif

//--- test/decoder_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decoder_tb;

    `include "decoder_ref.svh"

    localparam int MAX_CYCLES = 400;

    logic                  clock;
    logic                  reset;
    logic                  flush;
    decoder_pkg::word_t    instr;
    decoder_pkg::pc_t      pc;
    decoder_pkg::word_t    reg_src1;
    decoder_pkg::word_t    reg_src2;
    logic                  branch_eq;
    logic                  branch_gt;
    logic                  branch_lt;
    logic                  alu_add;
    logic                  alu_neg_src1;
    logic                  alu_neg_src2;
    logic                  pc_incr_to_res;
    logic                  jump_to_res;
    logic                  write_res_to_reg;
    logic                  src2_to_res;
    decoder_pkg::cycle_t   cycle_in_instr;
    decoder_pkg::reg_idx_t res_reg_idx;
    decoder_pkg::reg_idx_t src1_reg_idx;
    decoder_pkg::reg_idx_t src2_reg_idx;
    decoder_pkg::word_t    alu_src1;
    decoder_pkg::word_t    alu_src2;

    // Model of the registered state inside the DUT
    decoder_pkg::word_t  m_instr   = '0;
    decoder_pkg::word_t  m_prev    = '0;
    decoder_pkg::pc_t    m_pc      = '0;
    decoder_pkg::pc_t    m_pc_prev = '0;
    logic                m_flush   = 1'b0;
    decoder_pkg::cycle_t m_cycle   = '0;

    string test_name    = "none";
    int    errors       = 0;
    int    checks       = 0;
    int    tests        = 0;
    int    test_errors  = 0;
    int    cycle_count  = 0;
    int    pc_count     = 0;

    decoder_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic check_field(input string field, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error %s %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    always @(negedge clock) begin : compare_outputs
        decoder_pkg::word_t    first;
        decoder_pkg::actions_t act;
        ref_out_t              exp;
        first = (m_cycle == '0) ? m_instr : m_prev;
        exp   = decode_ref(first, m_instr, m_pc, m_pc_prev, m_flush, m_cycle, reg_src1, reg_src2);
        act   = {branch_eq, branch_gt, branch_lt, alu_add, alu_neg_src1, alu_neg_src2,
                 pc_incr_to_res, jump_to_res, write_res_to_reg, src2_to_res};
        check_field("actions", 16'(exp.actions), 16'(act));
        check_field("alu_src1", exp.alu_src1, alu_src1);
        check_field("alu_src2", exp.alu_src2, alu_src2);
        check_field("cycle", 16'(m_cycle), 16'(cycle_in_instr));
        check_field("res_idx", 16'(first[7:4]), 16'(res_reg_idx));
        check_field("src1_idx", 16'(first[11:8]), 16'(src1_reg_idx));
        check_field("src2_idx", 16'(first[15:12]), 16'(src2_reg_idx));
        if (reset) begin
            m_instr   = '0;
            m_prev    = '0;
            m_pc      = '0;
            m_pc_prev = '0;
            m_flush   = 1'b0;
            m_cycle   = '0;
        end else begin
            m_prev    = m_instr;  // Inputs now held are taken at the next edge
            m_pc_prev = m_pc;
            m_instr   = instr;
            m_pc      = pc;
            m_flush   = flush;
            m_cycle   = exp.cycle_next;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic drive_word(input decoder_pkg::word_t word, input logic flush_in);
        @(posedge clock);
        #5;
        instr    = word;
        pc       = decoder_pkg::pc_t'(pc_count);
        flush    = flush_in;
        reg_src1 = decoder_pkg::word_t'($urandom);
        reg_src2 = decoder_pkg::word_t'($urandom);
        pc_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    // Trailing NOP lets the last word be checked
    task automatic end_test();
        drive_word('0, 1'b0);
        #20;
        tests++;
        $display("test %s done, %0d errors", test_name, errors - test_errors);
    endtask

    initial begin : stimulus
        void'($urandom(41));
        reset    = 1'b1;
        flush    = 1'b0;
        instr    = '0;
        pc       = '0;
        reg_src1 = '0;
        reg_src2 = '0;

        start_test("reset");
        repeat (3) @(posedge clock);
        #5 reset = 1'b0;
        drive_word('0, 1'b0);
        end_test();

        start_test("add_sub");
        drive_word(make_r(decoder_pkg::ADD, 4'd1, 4'd2, 4'd3), 1'b0);
        drive_word(make_r(decoder_pkg::SUB, 4'd15, 4'd9, 4'd4), 1'b0);
        drive_word(make_r(decoder_pkg::ADD, 4'd7, 4'd0, 4'd12), 1'b0);
        end_test();

        start_test("loads");
        drive_word(make_u(decoder_pkg::LI, 4'd5, 4'd0), 1'b0);
        drive_word(16'hbeef, 1'b0);
        drive_word(make_u(decoder_pkg::LIL, 4'd6, 4'd11), 1'b0);
        drive_word(make_u(decoder_pkg::LI, 4'd2, 4'd9), 1'b0);
        drive_word(16'h1234, 1'b0);
        end_test();

        start_test("branches");
        drive_word(make_s(decoder_pkg::BEQ, 4'd1, 4'd2), 1'b0);
        drive_word(16'h0010, 1'b0);
        drive_word(make_s(decoder_pkg::BNEQ, 4'd3, 4'd4), 1'b0);
        drive_word(16'hfff0, 1'b0);
        drive_word(make_s(decoder_pkg::BGE, 4'd5, 4'd6), 1'b0);
        drive_word(16'h0042, 1'b0);
        drive_word(make_s(decoder_pkg::BLT, 4'd7, 4'd8), 1'b0);
        drive_word(16'h8001, 1'b0);
        end_test();

        start_test("jumps");
        drive_word(make_j(decoder_pkg::JAL, 4'd14, 4'd0), 1'b0);
        drive_word(16'h0100, 1'b0);
        drive_word(make_j(decoder_pkg::JALR, 4'd13, 4'd3), 1'b0);
        end_test();

        start_test("flush_unknown");
        drive_word(make_u(decoder_pkg::LI, 4'd5, 4'd0), 1'b0);
        drive_word(16'h5555, 1'b1);
        drive_word(make_s(decoder_pkg::BEQ, 4'd1, 4'd2), 1'b0);
        drive_word(16'h0020, 1'b1);
        drive_word(make_j(decoder_pkg::JAL, 4'd1, 4'd0), 1'b0);
        drive_word(16'h0300, 1'b1);
        drive_word(make_r(decoder_pkg::ADD, 4'd1, 4'd2, 4'd3), 1'b1);
        drive_word(16'h3214, 1'b0);  // Former memory opcodes 4, 5, 8 and 9
        drive_word(16'h3215, 1'b0);
        drive_word(16'h3218, 1'b0);
        drive_word(16'h3219, 1'b0);
        drive_word(16'h321f, 1'b0);
        drive_word(16'h2173, 1'b0);  // S-type, no such branch
        drive_word(16'h2501, 1'b0);  // U-type, no such load
        drive_word(16'h5212, 1'b0);  // J-type, no such jump
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/decoder_top.sv
`timescale 1ns/1ns
`default_nettype none

module decoder_top (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               flush,
    input  wire decoder_pkg::word_t instr,
    input  wire decoder_pkg::pc_t   pc,
    input  wire decoder_pkg::word_t reg_src1,
    input  wire decoder_pkg::word_t reg_src2,
    output logic                    branch_eq,
    output logic                    branch_gt,
    output logic                    branch_lt,
    output logic                    alu_add,
    output logic                    alu_neg_src1,
    output logic                    alu_neg_src2,
    output logic                    pc_incr_to_res,
    output logic                    jump_to_res,
    output logic                    write_res_to_reg,
    output logic                    src2_to_res,
    output decoder_pkg::cycle_t     cycle_in_instr,
    output decoder_pkg::reg_idx_t   res_reg_idx,
    output decoder_pkg::reg_idx_t   src1_reg_idx,  // To register file
    output decoder_pkg::reg_idx_t   src2_reg_idx,  // To register file
    output decoder_pkg::word_t      alu_src1,
    output decoder_pkg::word_t      alu_src2
);

    decoder_pkg::actions_t     actions;
    decoder_pkg::operand_sel_e src1_sel;
    decoder_pkg::operand_sel_e src2_sel;

    capture_if cap (.clock(clock), .reset(reset));

    instr_capture u_capture (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .instr (instr),
        .pc    (pc),
        .cap   (cap.capture)
    );

    instr_decode u_decode (
        .cap          (cap.decode),
        .actions      (actions),
        .src1_sel     (src1_sel),
        .src2_sel     (src2_sel),
        .res_reg_idx  (res_reg_idx),
        .src1_reg_idx (src1_reg_idx),
        .src2_reg_idx (src2_reg_idx)
    );

    operand_select u_select (
        .cap      (cap.select),
        .src1_sel (src1_sel),
        .src2_sel (src2_sel),
        .reg_src1 (reg_src1),
        .reg_src2 (reg_src2),
        .alu_src1 (alu_src1),
        .alu_src2 (alu_src2)
    );

    assign branch_eq        = actions.branch_eq;
    assign branch_gt        = actions.branch_gt;
    assign branch_lt        = actions.branch_lt;
    assign alu_add          = actions.alu_add;
    assign alu_neg_src1     = actions.alu_neg_src1;
    assign alu_neg_src2     = actions.alu_neg_src2;
    assign pc_incr_to_res   = actions.pc_incr_to_res;
    assign jump_to_res      = actions.jump_to_res;
    assign write_res_to_reg = actions.write_res_to_reg;
    assign src2_to_res      = actions.src2_to_res;
    assign cycle_in_instr   = cap.cycle;

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/1ns
`default_nettype none

module operand_select (
    capture_if.select                     cap,
    input  wire decoder_pkg::operand_sel_e src1_sel,
    input  wire decoder_pkg::operand_sel_e src2_sel,
    input  wire decoder_pkg::word_t        reg_src1,
    input  wire decoder_pkg::word_t        reg_src2,
    output decoder_pkg::word_t             alu_src1,
    output decoder_pkg::word_t             alu_src2
);

    decoder_pkg::word_t imma_ext;
    decoder_pkg::word_t pc_cur_ext;
    decoder_pkg::word_t pc_prev_ext;

    // Zero extension to operand width
    assign imma_ext = {{(decoder_pkg::WORD_WIDTH-decoder_pkg::IMMA_WIDTH){1'b0}},
                       cap.first_word[decoder_pkg::IMMA_LSB +: decoder_pkg::IMMA_WIDTH]};
    assign pc_cur_ext  = {{(decoder_pkg::WORD_WIDTH-decoder_pkg::PC_WIDTH){1'b0}}, cap.pc_cur};
    assign pc_prev_ext = {{(decoder_pkg::WORD_WIDTH-decoder_pkg::PC_WIDTH){1'b0}}, cap.pc_prev};

    function automatic decoder_pkg::word_t pick(input decoder_pkg::operand_sel_e sel);
        case (sel)
            decoder_pkg::SEL_REG1:    return reg_src1;
            decoder_pkg::SEL_REG2:    return reg_src2;
            decoder_pkg::SEL_IMMB:    return cap.imm_word;
            decoder_pkg::SEL_IMMA:    return imma_ext;
            decoder_pkg::SEL_PC_CUR:  return pc_cur_ext;
            decoder_pkg::SEL_PC_PREV: return pc_prev_ext;
            default:                  return '0;
        endcase
    endfunction

    always_comb begin
        alu_src1 = pick(src1_sel);
        alu_src2 = pick(src2_sel);
    end

endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    capture_if.decode                 cap,
    output decoder_pkg::actions_t     actions,
    output decoder_pkg::operand_sel_e src1_sel,
    output decoder_pkg::operand_sel_e src2_sel,
    output decoder_pkg::reg_idx_t     res_reg_idx,
    output decoder_pkg::reg_idx_t     src1_reg_idx,
    output decoder_pkg::reg_idx_t     src2_reg_idx
);

    logic [decoder_pkg::OPCODE_WIDTH-1:0] opcode;
    logic [decoder_pkg::FUNC_WIDTH-1:0]   func1;
    logic [decoder_pkg::FUNC_WIDTH-1:0]   func2;
    logic [decoder_pkg::FUNC_WIDTH-1:0]   func3;
    logic                                 second;

    assign opcode = cap.first_word[decoder_pkg::OPCODE_LSB +: decoder_pkg::OPCODE_WIDTH];
    assign func1  = cap.first_word[decoder_pkg::FUNC1_LSB +: decoder_pkg::FUNC_WIDTH];
    assign func2  = cap.first_word[decoder_pkg::FUNC2_LSB +: decoder_pkg::FUNC_WIDTH];
    assign func3  = cap.first_word[decoder_pkg::FUNC3_LSB +: decoder_pkg::FUNC_WIDTH];
    assign second = (cap.cycle == decoder_pkg::cycle_t'(1));

    assign res_reg_idx  = cap.first_word[decoder_pkg::RES_IDX_LSB +: decoder_pkg::REG_IDX_WIDTH];
    assign src1_reg_idx = cap.first_word[decoder_pkg::SRC1_IDX_LSB +: decoder_pkg::REG_IDX_WIDTH];
    assign src2_reg_idx = cap.first_word[decoder_pkg::SRC2_IDX_LSB +: decoder_pkg::REG_IDX_WIDTH];

    always_comb begin
        actions        = '0;
        src1_sel       = decoder_pkg::SEL_ZERO;
        src2_sel       = decoder_pkg::SEL_ZERO;
        cap.cycle_next = '0;

        if (!cap.flushed) begin
            case (opcode)
                decoder_pkg::ADD, decoder_pkg::SUB: begin
                    actions.alu_add          = 1'b1;
                    actions.alu_neg_src2     = (opcode == decoder_pkg::SUB);
                    actions.write_res_to_reg = 1'b1;
                    src1_sel                 = decoder_pkg::SEL_REG1;
                    src2_sel                 = decoder_pkg::SEL_REG2;
                end
                decoder_pkg::U_TYPE: begin
                    if (func2 == decoder_pkg::LIL || (func2 == decoder_pkg::LI && second)) begin
                        actions.write_res_to_reg = 1'b1;
                        actions.src2_to_res      = 1'b1;
                        src2_sel = (func2 == decoder_pkg::LI) ? decoder_pkg::SEL_IMMB
                                                              : decoder_pkg::SEL_IMMA;
                    end else if (func2 == decoder_pkg::LI) begin
                        cap.cycle_next = decoder_pkg::cycle_t'(1);  // Wait for immediate word
                    end
                end
                decoder_pkg::S_TYPE: begin
                    case (func1)
                        decoder_pkg::BEQ:  actions.branch_eq = 1'b1;
                        decoder_pkg::BNEQ: begin
                            actions.branch_gt = 1'b1;
                            actions.branch_lt = 1'b1;
                        end
                        decoder_pkg::BGE: begin
                            actions.branch_eq = 1'b1;
                            actions.branch_gt = 1'b1;
                        end
                        decoder_pkg::BLT:  actions.branch_lt = 1'b1;
                        default: ;
                    endcase
                    if (actions.branch_eq || actions.branch_gt || actions.branch_lt) begin
                        actions.alu_add = 1'b1;
                        if (second) begin
                            // Branch target from offset and PC of the branch word
                            src1_sel = decoder_pkg::SEL_IMMB;
                            src2_sel = decoder_pkg::SEL_PC_PREV;
                        end else begin
                            cap.cycle_next = decoder_pkg::cycle_t'(1);
                            src1_sel       = decoder_pkg::SEL_REG1;
                            src2_sel       = decoder_pkg::SEL_REG2;
                            actions.alu_neg_src1 = (func1 == decoder_pkg::BEQ) ||
                                                   (func1 == decoder_pkg::BNEQ);
                            actions.alu_neg_src2 = !actions.alu_neg_src1;
                        end
                    end
                end
                decoder_pkg::J_TYPE: begin
                    if (func3 == decoder_pkg::JALR || (func3 == decoder_pkg::JAL && second)) begin
                        actions.alu_add          = 1'b1;
                        actions.pc_incr_to_res   = 1'b1;
                        actions.jump_to_res      = 1'b1;
                        actions.write_res_to_reg = 1'b1;
                        if (func3 == decoder_pkg::JAL) begin
                            src1_sel = decoder_pkg::SEL_IMMB;
                            src2_sel = decoder_pkg::SEL_PC_PREV;
                        end else begin
                            src1_sel = decoder_pkg::SEL_REG1;
                            src2_sel = decoder_pkg::SEL_PC_CUR;
                        end
                    end else if (func3 == decoder_pkg::JAL) begin
                        cap.cycle_next = decoder_pkg::cycle_t'(1);
                    end
                end
                default: ;  // NOP and unknown words
            endcase
        end
    end

    // Link register is always written on a jump
    jump_writes_link: assert property (@(posedge cap.clock) disable iff (cap.reset)
        actions.jump_to_res |-> actions.write_res_to_reg);

    flush_clears_all: assert property (@(posedge cap.clock) disable iff (cap.reset)
        cap.flushed |-> (actions == '0) && (cap.cycle_next == '0));

endmodule

`default_nettype wire

//--- logic/instr_capture.sv
`timescale 1ns/1ns
`default_nettype none

module instr_capture (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               flush,
    input  wire decoder_pkg::word_t instr,
    input  wire decoder_pkg::pc_t   pc,
    capture_if.capture              cap
);

    decoder_pkg::word_t  instr_q;
    decoder_pkg::word_t  instr_prev_q;
    decoder_pkg::pc_t    pc_q;
    decoder_pkg::pc_t    pc_prev_q;
    logic                flush_q;
    decoder_pkg::cycle_t cycle_q;

    // Sampled inputs
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            instr_q <= '0;
            pc_q    <= '0;
            flush_q <= 1'b0;
        end else begin
            instr_q <= instr;
            pc_q    <= pc;
            flush_q <= flush;
        end
    end

    // One word back, for the second cycle of two-cycle instructions
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            instr_prev_q <= '0;
            pc_prev_q    <= '0;
        end else begin
            instr_prev_q <= instr_q;
            pc_prev_q    <= pc_q;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cap.cycle_next;
        end
    end

    // Opcode word stays visible while the immediate word is registered
    assign cap.first_word = (cycle_q == '0) ? instr_q : instr_prev_q;

    assign cap.imm_word = instr_q;
    assign cap.pc_cur   = pc_q;
    assign cap.pc_prev  = pc_prev_q;
    assign cap.flushed  = flush_q;
    assign cap.cycle    = cycle_q;

    // No instruction is longer than two cycles
    cycle_in_range: assert property (@(posedge clock) disable iff (reset)
        cycle_q <= decoder_pkg::cycle_t'(1));

endmodule

`default_nettype wire

//--- logic/capture_if.sv
`timescale 1ns/1ns
`default_nettype none

interface capture_if (
    input wire logic clock,
    input wire logic reset
);

    decoder_pkg::word_t  first_word;
    decoder_pkg::word_t  imm_word;   // Second word of a two-word instruction
    decoder_pkg::pc_t    pc_cur;
    decoder_pkg::pc_t    pc_prev;
    logic                flushed;
    decoder_pkg::cycle_t cycle;
    decoder_pkg::cycle_t cycle_next;

    modport capture (output first_word, imm_word, pc_cur, pc_prev, flushed, cycle,
                     input cycle_next);

    modport decode (input clock, reset, first_word, flushed, cycle, output cycle_next);

    modport select (input imm_word, first_word, pc_cur, pc_prev);

endinterface

`default_nettype wire

//--- logic/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    localparam int WORD_WIDTH    = 16;
    localparam int PC_WIDTH      = 12;
    localparam int REG_IDX_WIDTH = 4;
    localparam int IMMA_WIDTH    = 4;
    localparam int CYCLE_WIDTH   = 3;
    localparam int OPCODE_WIDTH  = 4;
    localparam int FUNC_WIDTH    = 4;

    // Lowest bit of each instruction field
    localparam int OPCODE_LSB   = 0;
    localparam int FUNC1_LSB    = 4;
    localparam int FUNC2_LSB    = 8;
    localparam int FUNC3_LSB    = 12;
    localparam int RES_IDX_LSB  = 4;
    localparam int SRC1_IDX_LSB = 8;
    localparam int SRC2_IDX_LSB = 12;
    localparam int IMMA_LSB     = 12;

    typedef logic [WORD_WIDTH-1:0]    word_t;
    typedef logic [PC_WIDTH-1:0]      pc_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [CYCLE_WIDTH-1:0]   cycle_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP    = 4'd0,
        U_TYPE = 4'd1,
        J_TYPE = 4'd2,
        S_TYPE = 4'd3,
        ADD    = 4'd6,
        SUB    = 4'd7
    } opcode_e;

    typedef enum logic [FUNC_WIDTH-1:0] {
        BEQ  = 4'd0,
        BNEQ = 4'd1,
        BGE  = 4'd2,
        BLT  = 4'd3
    } branch_func_e;

    typedef enum logic [FUNC_WIDTH-1:0] {
        LI  = 4'd3,
        LIL = 4'd4  // 4-bit immediate, no sign extension
    } imm_func_e;

    typedef enum logic [FUNC_WIDTH-1:0] {
        JAL  = 4'd0,
        JALR = 4'd1
    } jump_func_e;

    typedef enum logic [2:0] {
        SEL_ZERO,
        SEL_REG1,
        SEL_REG2,
        SEL_IMMB,
        SEL_IMMA,
        SEL_PC_CUR,
        SEL_PC_PREV
    } operand_sel_e;

    typedef struct packed {
        logic branch_eq;
        logic branch_gt;
        logic branch_lt;
        logic alu_add;
        logic alu_neg_src1;
        logic alu_neg_src2;
        logic pc_incr_to_res;
        logic jump_to_res;
        logic write_res_to_reg;
        logic src2_to_res;  // Result taken from src2, bypassing the adder
    } actions_t;

endpackage

`default_nettype wire
